/* vlog.f */
logic/icache_conf_pkg.sv
logic/l2_bus_pkg.sv
logic/tag_array.sv
logic/data_array.sv
logic/icache.sv
logic/uc_load.sv
logic/l2_arbiter.sv
logic/l2_mem.sv
logic/icache_subsys.sv
sim/tb_icache_subsys.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_icache_subsys
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_icache_subsys.sv */
// testbench for the fetch subsystem, random fetches and uncached loads checked against a model
module tb_icache_subsys;
  import icache_conf_pkg::*;
  import l2_bus_pkg::*;

  localparam int WAIT_LIMIT = 200;
  localparam int N_FETCH    = 400;
  localparam int N_LOAD     = 80;

  logic     i_clk;
  logic     i_reset_n;
  logic     i_flush_valid;
  logic     i_fence_i;
  ic_req_t  i_s0_req;
  logic     o_s0_ready;
  ic_resp_t o_s2_resp;
  logic     o_s2_miss;
  vaddr_t   o_s2_miss_vaddr;
  uc_req_t  i_uc_req;
  logic     o_uc_ready;
  uc_resp_t o_uc_resp;
  logic     i_mem_wr;
  l2_idx_t  i_mem_addr;
  l2_data_t i_mem_data;

  integer   seed;
  l2_data_t mem_copy [L2_LINES];
  tag_t     m_tag    [ICACHE_SETS][ICACHE_WAYS];  // cache model
  logic     m_vld    [ICACHE_SETS][ICACHE_WAYS];
  way_t     m_vict   [ICACHE_SETS];
  int       n_hit;
  int       n_miss;
  int       n_flush;
  int       n_fence;

  icache_subsys dut (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush_valid   (i_flush_valid),
    .i_fence_i       (i_fence_i),
    .i_s0_req        (i_s0_req),
    .o_s0_ready      (o_s0_ready),
    .o_s2_resp       (o_s2_resp),
    .o_s2_miss       (o_s2_miss),
    .o_s2_miss_vaddr (o_s2_miss_vaddr),
    .i_uc_req        (i_uc_req),
    .o_uc_ready      (o_uc_ready),
    .o_uc_resp       (o_uc_resp),
    .i_mem_wr        (i_mem_wr),
    .i_mem_addr      (i_mem_addr),
    .i_mem_data      (i_mem_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("TEST FAIL");
    $fatal(1, "wait limit reached");
  endtask

  // leaves the caller 1 unit after a rising edge with the cache idle
  task automatic wait_fetch_ready;
    int cnt;
    cnt = 0;
    @(negedge i_clk);
    while (!o_s0_ready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) report_timeout("fetch ready after a refill");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
  endtask

  // 8 tags over 4 sets, so ways get evicted
  function automatic vaddr_t fetch_addr(input int r);
    logic [4:0] sel;
    logic [2:0] ofs;
    sel = r[4:0];
    ofs = r[10:8];
    return {6'd0, sel[4:2], 2'b00, sel[1:0], ofs};
  endfunction

  task automatic fetch_and_check(input vaddr_t a, input logic flush);
    set_t    fset;
    tag_t    ftag;
    be_t     be_exp;
    logic    hit;
    logic    exp_valid;
    logic    exp_miss;
    fset = a[ICACHE_OFS_W +: ICACHE_SET_W];
    ftag = a[VADDR_W-1 -: ICACHE_TAG_W];
    hit  = 1'b0;
    for (int w = 0; w < ICACHE_WAYS; w++) begin
      if (m_vld[fset][w] && m_tag[fset][w] == ftag) hit = 1'b1;
    end
    for (int b = 0; b < ICACHE_LINE_B; b++) begin
      be_exp[b] = (b >= a[ICACHE_OFS_W-1:0]);  // bytes below the offset are masked
    end
    exp_valid = hit & ~flush;
    exp_miss  = ~hit & ~flush;

    wait_fetch_ready();
    i_s0_req.valid = 1'b1;
    i_s0_req.vaddr = a;
    @(posedge i_clk);  // accepted here
    #1;
    i_s0_req.valid = 1'b0;
    @(negedge i_clk);
    check_val("o_s2_resp.valid (s1)", 64'(o_s2_resp.valid), 64'(0));
    check_val("o_s2_miss (s1)", 64'(o_s2_miss), 64'(0));
    @(posedge i_clk);
    #1;
    i_flush_valid = flush;
    @(negedge i_clk);
    check_val("o_s2_resp.valid", 64'(o_s2_resp.valid), 64'(exp_valid));
    check_val("o_s2_miss", 64'(o_s2_miss), 64'(exp_miss));
    if (flush) begin
      n_flush++;
    end else if (hit) begin
      check_val("o_s2_resp.addr", 64'(o_s2_resp.addr), 64'(a[VADDR_W-1:ICACHE_OFS_W]));
      check_val("o_s2_resp.data", o_s2_resp.data, mem_copy[a[L2_OFS_W +: L2_IDX_W]]);
      check_val("o_s2_resp.be", 64'(o_s2_resp.be), 64'(be_exp));
      n_hit++;
    end else begin
      check_val("o_s2_miss_vaddr", 64'(o_s2_miss_vaddr), 64'(a));
      m_tag[fset][m_vict[fset]] = ftag;  // refill goes to the victim way
      m_vld[fset][m_vict[fset]] = 1'b1;
      m_vict[fset] = ~m_vict[fset];
      n_miss++;
    end
    @(posedge i_clk);
    #1;
    i_flush_valid = 1'b0;
  endtask

  task automatic fence_cache;
    wait_fetch_ready();
    i_fence_i = 1'b1;
    @(posedge i_clk);
    #1;
    i_fence_i = 1'b0;
    for (int s = 0; s < ICACHE_SETS; s++) begin
      for (int w = 0; w < ICACHE_WAYS; w++) begin
        m_vld[s][w] = 1'b0;
      end
    end
    n_fence++;
  endtask

  task automatic load_and_check(input l2_addr_t a);
    l2_data_t line;
    uc_word_t exp;
    int       cnt;
    line = mem_copy[a[L2_OFS_W +: L2_IDX_W]];
    exp  = a[2] ? line[63:32] : line[31:0];  // bit 2 picks the upper half
    cnt  = 0;
    @(negedge i_clk);
    while (!o_uc_ready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) report_timeout("uncached port ready");
      @(negedge i_clk);
    end
    @(posedge i_clk);
    #1;
    i_uc_req.valid = 1'b1;
    i_uc_req.addr  = a;
    @(posedge i_clk);
    #1;
    i_uc_req.valid = 1'b0;
    cnt = 0;
    @(negedge i_clk);
    while (!o_uc_resp.valid) begin
      cnt++;
      if (cnt > WAIT_LIMIT) report_timeout("uncached load response");
      @(negedge i_clk);
    end
    check_val("o_uc_resp.data", 64'(o_uc_resp.data), 64'(exp));
  endtask

  task automatic run_fetches;
    int r;
    for (int n = 0; n < N_FETCH; n++) begin
      r = $random(seed);
      if (r[7:3] == 5'd0) begin
        fence_cache();
      end else begin
        fetch_and_check(fetch_addr(r), r[15:12] == 4'd0);
      end
    end
  endtask

  task automatic run_loads;
    int r;
    for (int k = 0; k < N_LOAD; k++) begin
      r = $random(seed);
      repeat (r[2:0]) @(posedge i_clk);  // idle gap
      load_and_check(r[31:16]);
    end
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    seed          = 64;
    i_reset_n     = 1'b0;
    i_flush_valid = 1'b0;
    i_fence_i     = 1'b0;
    i_s0_req      = '0;
    i_uc_req      = '0;
    i_mem_wr      = 1'b0;
    i_mem_addr    = '0;
    i_mem_data    = '0;
    n_hit         = 0;
    n_miss        = 0;
    n_flush       = 0;
    n_fence       = 0;
    for (int s = 0; s < ICACHE_SETS; s++) begin
      m_vict[s] = 1'b0;
      for (int w = 0; w < ICACHE_WAYS; w++) begin
        m_vld[s][w] = 1'b0;
        m_tag[s][w] = '0;
      end
    end

    repeat (5) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    @(negedge i_clk);
    check_val("o_s2_resp.valid", 64'(o_s2_resp.valid), 64'(0));
    check_val("o_s2_miss", 64'(o_s2_miss), 64'(0));
    check_val("o_uc_resp.valid", 64'(o_uc_resp.valid), 64'(0));
    check_val("o_s0_ready", 64'(o_s0_ready), 64'(1));
    check_val("o_uc_ready", 64'(o_uc_ready), 64'(1));
    check_val("ic l2 req valid", 64'(dut.w_ic_l2_req.valid), 64'(0));
    check_val("uc l2 req valid", 64'(dut.w_uc_l2_req.valid), 64'(0));

    @(posedge i_clk);
    #1;
    for (int i = 0; i < L2_LINES; i++) begin
      i_mem_wr    = 1'b1;
      i_mem_addr  = l2_idx_t'(i);
      i_mem_data  = {$random(seed), $random(seed)};
      mem_copy[i] = i_mem_data;
      @(posedge i_clk);
      #1;
    end
    i_mem_wr = 1'b0;

    fork
      run_fetches();
      run_loads();
    join

    $display("hits %0d misses %0d flushes %0d fences %0d", n_hit, n_miss, n_flush, n_fence);
    if (n_hit == 0 || n_miss == 0 || n_flush == 0 || n_fence == 0) begin
      $display("random stimulus missed a hit, miss, flush or fence case");
      $display("TEST FAIL");
      $fatal(1, "incomplete stimulus");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* logic/icache_subsys.sv */
// fetch memory subsystem top, cache and uncached port sharing one L2 memory via the arbiter
module icache_subsys (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_flush_valid,
  input  logic                      i_fence_i,
  input  icache_conf_pkg::ic_req_t  i_s0_req,
  output logic                      o_s0_ready,
  output icache_conf_pkg::ic_resp_t o_s2_resp,
  output logic                      o_s2_miss,
  output icache_conf_pkg::vaddr_t   o_s2_miss_vaddr,
  input  l2_bus_pkg::uc_req_t       i_uc_req,
  output logic                      o_uc_ready,
  output l2_bus_pkg::uc_resp_t      o_uc_resp,
  input  logic                      i_mem_wr,
  input  l2_bus_pkg::l2_idx_t       i_mem_addr,
  input  l2_bus_pkg::l2_data_t      i_mem_data
);
  import l2_bus_pkg::*;

  l2_req_t  w_ic_l2_req;
  l2_req_t  w_uc_l2_req;
  l2_req_t  w_mem_req;
  l2_resp_t w_mem_resp;
  l2_resp_t w_l2_resp;  // copied to both peers
  logic     w_ic_grant;
  logic     w_uc_grant;

  icache u_icache (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_flush_valid   (i_flush_valid),
    .i_fence_i       (i_fence_i),
    .i_s0_req        (i_s0_req),
    .o_s0_ready      (o_s0_ready),
    .o_s2_resp       (o_s2_resp),
    .o_s2_miss       (o_s2_miss),
    .o_s2_miss_vaddr (o_s2_miss_vaddr),
    .o_l2_req        (w_ic_l2_req),
    .i_l2_grant      (w_ic_grant),
    .i_l2_resp       (w_l2_resp)
  );

  uc_load u_uc_load (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_uc_req   (i_uc_req),
    .o_uc_ready (o_uc_ready),
    .o_uc_resp  (o_uc_resp),
    .o_l2_req   (w_uc_l2_req),
    .i_l2_grant (w_uc_grant),
    .i_l2_resp  (w_l2_resp)
  );

  l2_arbiter u_l2_arbiter (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ic_req   (w_ic_l2_req),
    .i_uc_req   (w_uc_l2_req),
    .o_ic_grant (w_ic_grant),
    .o_uc_grant (w_uc_grant),
    .o_mem_req  (w_mem_req),
    .i_mem_resp (w_mem_resp),
    .o_resp     (w_l2_resp)
  );

  l2_mem u_l2_mem (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_req      (w_mem_req),
    .o_resp     (w_mem_resp),
    .i_mem_wr   (i_mem_wr),
    .i_mem_addr (i_mem_addr),
    .i_mem_data (i_mem_data)
  );

endmodule

/* logic/l2_mem.sv */
// L2 backing memory, fixed-latency pipelined line reads and a preload write port
module l2_mem (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  l2_bus_pkg::l2_req_t  i_req,
  output l2_bus_pkg::l2_resp_t o_resp,
  input  logic                 i_mem_wr,
  input  l2_bus_pkg::l2_idx_t  i_mem_addr,
  input  l2_bus_pkg::l2_data_t i_mem_data
);
  import l2_bus_pkg::*;

  l2_data_t              r_mem [L2_LINES];
  logic [L2_LATENCY-1:0] r_vld;
  l2_tag_t               r_tag  [L2_LATENCY];
  l2_data_t              r_data [L2_LATENCY];
  l2_idx_t               w_rd_idx;

  assign w_rd_idx = i_req.addr[L2_OFS_W +: L2_IDX_W];

  always_ff @(posedge i_clk) begin
    if (i_mem_wr) begin
      r_mem[i_mem_addr] <= i_mem_data;
    end
  end

  // ========================================
  // read pipeline
  // ========================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_vld <= '0;
    end else begin
      r_vld <= {r_vld[L2_LATENCY-2:0], i_req.valid};
    end
  end

  always_ff @(posedge i_clk) begin
    r_tag[0]  <= i_req.tag;
    r_data[0] <= r_mem[w_rd_idx];  // array read in the accept cycle
    for (int i = 1; i < L2_LATENCY; i++) begin
      r_tag[i]  <= r_tag[i-1];
      r_data[i] <= r_data[i-1];
    end
  end

  assign o_resp.valid = r_vld[L2_LATENCY-1];
  assign o_resp.tag   = r_tag[L2_LATENCY-1];
  assign o_resp.data  = r_data[L2_LATENCY-1];

endmodule

/* logic/l2_arbiter.sv */
// round-robin arbiter putting the cache and the uncached port on one L2 memory
module l2_arbiter (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  l2_bus_pkg::l2_req_t  i_ic_req,
  input  l2_bus_pkg::l2_req_t  i_uc_req,
  output logic                 o_ic_grant,
  output logic                 o_uc_grant,
  output l2_bus_pkg::l2_req_t  o_mem_req,
  input  l2_bus_pkg::l2_resp_t i_mem_resp,
  output l2_bus_pkg::l2_resp_t o_resp
);
  import l2_bus_pkg::*;

  l2_tag_t r_last;  // requester granted last time

  // on a tie the peer that lost last time goes first
  assign o_ic_grant = i_ic_req.valid & (~i_uc_req.valid | (r_last == L2_TAG_UC));
  assign o_uc_grant = i_uc_req.valid & ~o_ic_grant;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last <= L2_TAG_UC;  // cache wins the first tie
    end else begin
      if (o_ic_grant) begin
        r_last <= L2_TAG_IC;
      end else if (o_uc_grant) begin
        r_last <= L2_TAG_UC;
      end
    end
  end

  // idle bus forwards the cache request with valid low
  assign o_mem_req = o_uc_grant ? i_uc_req : i_ic_req;

  // both peers see every response and pick theirs by tag
  assign o_resp = i_mem_resp;

endmodule

/* logic/uc_load.sv */
// uncached word load port, one L2 line read per request, returns the addressed 32-bit half
module uc_load (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  l2_bus_pkg::uc_req_t  i_uc_req,
  output logic                 o_uc_ready,
  output l2_bus_pkg::uc_resp_t o_uc_resp,
  output l2_bus_pkg::l2_req_t  o_l2_req,
  input  logic                 i_l2_grant,
  input  l2_bus_pkg::l2_resp_t i_l2_resp
);
  import l2_bus_pkg::*;

  typedef enum logic [1:0] {UC_IDLE, UC_REQ, UC_WAIT} uc_state_t;

  uc_state_t r_state;
  l2_addr_t  r_addr;
  logic      w_resp_hit;

  assign w_resp_hit = (r_state == UC_WAIT) & i_l2_resp.valid & (i_l2_resp.tag == L2_TAG_UC);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= UC_IDLE;
    end else begin
      case (r_state)
        UC_IDLE: if (i_uc_req.valid) r_state <= UC_REQ;
        UC_REQ:  if (i_l2_grant) r_state <= UC_WAIT;
        default: if (w_resp_hit) r_state <= UC_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_uc_req.valid & o_uc_ready) begin
      r_addr <= i_uc_req.addr;
    end
  end

  assign o_uc_ready = (r_state == UC_IDLE);

  assign o_l2_req.valid = (r_state == UC_REQ);
  assign o_l2_req.addr  = {r_addr[L2_ADDR_W-1:L2_OFS_W], {L2_OFS_W{1'b0}}};
  assign o_l2_req.tag   = L2_TAG_UC;

  // bit 2 picks the upper word
  assign o_uc_resp.valid = w_resp_hit;
  assign o_uc_resp.data  = i_l2_resp.data[r_addr[L2_OFS_W-1] * UC_WORD_W +: UC_WORD_W];

endmodule

/* logic/icache.sv */
// two-way instruction cache with a three-stage lookup and a single-line refill over the L2 bus
module icache (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  logic                      i_flush_valid,
  input  logic                      i_fence_i,
  input  icache_conf_pkg::ic_req_t  i_s0_req,
  output logic                      o_s0_ready,
  output icache_conf_pkg::ic_resp_t o_s2_resp,
  output logic                      o_s2_miss,
  output icache_conf_pkg::vaddr_t   o_s2_miss_vaddr,
  output l2_bus_pkg::l2_req_t       o_l2_req,
  input  logic                      i_l2_grant,
  input  l2_bus_pkg::l2_resp_t      i_l2_resp
);
  import icache_conf_pkg::*;
  import l2_bus_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_WAIT_INV} miss_state_t;

  miss_state_t            r_state;
  logic                   w_s0_fire;
  logic                   r_s1_valid;
  vaddr_t                 r_s1_vaddr;
  logic [ICACHE_WAYS-1:0] w_s1_hit_oh;
  logic                   r_s2_valid;
  vaddr_t                 r_s2_vaddr;
  logic [ICACHE_WAYS-1:0] r_s2_hit_oh;
  line_t                  w_s2_data [ICACHE_WAYS];
  line_t                  w_s2_line;
  vaddr_t                 r_miss_vaddr;
  vaddr_t                 w_req_vaddr;
  way_t                   r_victim [ICACHE_SETS];
  logic                   w_fill;
  set_t                   w_fill_set;
  way_t                   w_fill_way;
  set_t                   w_tag_addr;
  set_t                   w_dat_addr;

  assign w_s0_fire  = i_s0_req.valid & o_s0_ready;
  assign w_fill     = i_l2_resp.valid & (i_l2_resp.tag == L2_TAG_IC) &
                      ((r_state == ST_WAIT) | (r_state == ST_WAIT_INV));
  assign w_fill_set = r_miss_vaddr[ICACHE_OFS_W +: ICACHE_SET_W];
  assign w_fill_way = r_victim[w_fill_set];

  // fetch is stalled during a fill, so the arrays never see both
  assign w_tag_addr = w_fill ? w_fill_set : i_s0_req.vaddr[ICACHE_OFS_W +: ICACHE_SET_W];
  assign w_dat_addr = w_fill ? w_fill_set : r_s1_vaddr[ICACHE_OFS_W +: ICACHE_SET_W];

  for (genvar w = 0; w < ICACHE_WAYS; w++) begin : g_way
    logic w_way_fill;
    logic w_tag_valid;
    tag_t w_tag;

    assign w_way_fill = w_fill & (w_fill_way == way_t'(w));

    tag_array #(.WIDTH(ICACHE_TAG_W), .DEPTH(ICACHE_SETS)) u_tag (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_tag_clear (i_fence_i),
      .i_wr        (w_way_fill & (r_state == ST_WAIT)),  // invalidated fill leaves tag invalid
      .i_addr      (w_tag_addr),
      .i_tag       (r_miss_vaddr[VADDR_W-1 -: ICACHE_TAG_W]),
      .o_tag       (w_tag),
      .o_tag_valid (w_tag_valid)
    );

    data_array #(.WIDTH(ICACHE_LINE_W), .DEPTH(ICACHE_SETS)) u_data (
      .i_clk  (i_clk),
      .i_wr   (w_way_fill),
      .i_addr (w_dat_addr),
      .i_data (i_l2_resp.data),
      .o_data (w_s2_data[w])
    );

    assign w_s1_hit_oh[w] = w_tag_valid & (w_tag == r_s1_vaddr[VADDR_W-1 -: ICACHE_TAG_W]);
  end

  // ========================================
  // lookup pipeline
  // ========================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
    end else begin
      r_s1_valid <= w_s0_fire;
      r_s2_valid <= r_s1_valid & ~i_flush_valid & ~o_s2_miss;  // drop the one behind a miss
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_vaddr  <= i_s0_req.vaddr;
    r_s2_vaddr  <= r_s1_vaddr;
    r_s2_hit_oh <= w_s1_hit_oh;
  end

  always_comb begin
    w_s2_line = '0;
    for (int i = 0; i < ICACHE_WAYS; i++) begin
      w_s2_line |= w_s2_data[i] & {ICACHE_LINE_W{r_s2_hit_oh[i]}};
    end
  end

  assign o_s2_resp.valid = r_s2_valid & (|r_s2_hit_oh) & ~i_flush_valid;
  assign o_s2_resp.addr  = r_s2_vaddr[VADDR_W-1:ICACHE_OFS_W];
  assign o_s2_resp.data  = w_s2_line;
  assign o_s2_resp.be    = {ICACHE_LINE_B{1'b1}} << r_s2_vaddr[ICACHE_OFS_W-1:0];

  assign o_s2_miss       = r_s2_valid & ~(|r_s2_hit_oh) & ~i_flush_valid;
  assign o_s2_miss_vaddr = r_s2_vaddr;
  assign o_s0_ready      = (r_state == ST_IDLE) & ~o_s2_miss;

  // ========================================
  // miss handling
  // ========================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_IDLE;
    end else begin
      case (r_state)
        ST_IDLE: begin
          if (o_s2_miss) begin
            if (!i_l2_grant) begin
              r_state <= ST_REQ;
            end else begin
              r_state <= i_fence_i ? ST_WAIT_INV : ST_WAIT;
            end
          end
        end
        ST_REQ: begin
          // read not issued yet, so a fence here still gets fresh data
          if (i_l2_grant) begin
            r_state <= i_fence_i ? ST_WAIT_INV : ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (w_fill) begin
            r_state <= ST_IDLE;
          end else if (i_fence_i) begin
            r_state <= ST_WAIT_INV;
          end
        end
        default: begin
          if (w_fill) begin
            r_state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == ST_IDLE) begin
      r_miss_vaddr <= r_s2_vaddr;  // last idle cycle holds the miss
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < ICACHE_SETS; i++) begin
        r_victim[i] <= 1'b0;
      end
    end else if (w_fill) begin
      r_victim[w_fill_set] <= ~r_victim[w_fill_set];
    end
  end

  // request goes out in the miss cycle itself
  assign w_req_vaddr    = (r_state == ST_IDLE) ? r_s2_vaddr : r_miss_vaddr;
  assign o_l2_req.valid = (r_state == ST_REQ) | ((r_state == ST_IDLE) & o_s2_miss);
  assign o_l2_req.addr  = {w_req_vaddr[VADDR_W-1:ICACHE_OFS_W], {ICACHE_OFS_W{1'b0}}};
  assign o_l2_req.tag   = L2_TAG_IC;

endmodule

/* logic/data_array.sv */
// single-port line memory for one cache way, data appears the cycle after the address
module data_array #(
  parameter int WIDTH = 64,
  parameter int DEPTH = 16
) (
  input  logic                     i_clk,
  input  logic                     i_wr,
  input  logic [$clog2(DEPTH)-1:0] i_addr,
  input  logic [WIDTH-1:0]         i_data,
  output logic [WIDTH-1:0]         o_data
);

  logic [WIDTH-1:0] r_mem [DEPTH];

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_mem[i_addr] <= i_data;
    end
    o_data <= r_mem[i_addr];
  end

endmodule

/* logic/tag_array.sv */
// tag store for one cache way, registered read, valid bits cleared together by fence
module tag_array #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 16
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  logic                     i_tag_clear,
  input  logic                     i_wr,
  input  logic [$clog2(DEPTH)-1:0] i_addr,
  input  logic [WIDTH-1:0]         i_tag,
  output logic [WIDTH-1:0]         o_tag,
  output logic                     o_tag_valid
);

  logic [WIDTH-1:0] r_tag [DEPTH];
  logic [DEPTH-1:0] r_valid;

  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tag[i_addr] <= i_tag;
    end
    o_tag <= r_tag[i_addr];  // old contents on a same-cycle write
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid     <= '0;
      o_tag_valid <= 1'b0;
    end else begin
      if (i_tag_clear) begin
        r_valid <= '0;  // clear wins over a write
      end else if (i_wr) begin
        r_valid[i_addr] <= 1'b1;
      end
      o_tag_valid <= r_valid[i_addr];
    end
  end

endmodule

/* logic/l2_bus_pkg.sv */
// shared L2 read bus definitions for the cache, the uncached port, the arbiter and the memory
package l2_bus_pkg;

  localparam int L2_ADDR_W  = 16;
  localparam int L2_DATA_W  = 64;
  localparam int L2_OFS_W   = 3;   // byte offset inside a line
  localparam int L2_LINES   = 256;
  localparam int L2_IDX_W   = $clog2(L2_LINES);
  localparam int L2_TAG_W   = 1;
  localparam int L2_LATENCY = 3;
  localparam int UC_WORD_W  = 32;

  typedef logic [L2_ADDR_W-1:0] l2_addr_t;
  typedef logic [L2_DATA_W-1:0] l2_data_t;
  typedef logic [L2_IDX_W-1:0]  l2_idx_t;
  typedef logic [L2_TAG_W-1:0]  l2_tag_t;
  typedef logic [UC_WORD_W-1:0] uc_word_t;

  localparam l2_tag_t L2_TAG_IC = 1'b0;
  localparam l2_tag_t L2_TAG_UC = 1'b1;

  typedef struct packed {
    logic     valid;
    l2_addr_t addr;
    l2_tag_t  tag;
  } l2_req_t;

  typedef struct packed {
    logic     valid;
    l2_tag_t  tag;
    l2_data_t data;
  } l2_resp_t;

  typedef struct packed {
    logic     valid;
    l2_addr_t addr;
  } uc_req_t;

  typedef struct packed {
    logic     valid;
    uc_word_t data;
  } uc_resp_t;

endpackage

/* logic/icache_conf_pkg.sv */
// icache geometry, address fields and fetch-side structs, imported by the cache and the top
package icache_conf_pkg;

  localparam int VADDR_W       = 16;
  localparam int ICACHE_WAYS   = 2;
  localparam int ICACHE_SET_W  = 4;
  localparam int ICACHE_SETS   = 1 << ICACHE_SET_W;
  localparam int ICACHE_LINE_B = 8;
  localparam int ICACHE_OFS_W  = 3;
  localparam int ICACHE_LINE_W = ICACHE_LINE_B * 8;
  localparam int ICACHE_TAG_W  = VADDR_W - ICACHE_SET_W - ICACHE_OFS_W;

  typedef logic [VADDR_W-1:0]              vaddr_t;
  typedef logic [VADDR_W-ICACHE_OFS_W-1:0] laddr_t;  // line-aligned address
  typedef logic [ICACHE_LINE_W-1:0]        line_t;
  typedef logic [ICACHE_LINE_B-1:0]        be_t;
  typedef logic [ICACHE_TAG_W-1:0]         tag_t;
  typedef logic [ICACHE_SET_W-1:0]         set_t;
  typedef logic                            way_t;

  typedef struct packed {
    logic   valid;
    vaddr_t vaddr;
  } ic_req_t;

  typedef struct packed {
    logic   valid;
    laddr_t addr;
    line_t  data;
    be_t    be;
  } ic_resp_t;

endpackage
